/* common/alu_if.sv */
interface alu_if import dsp_pkg::*; ();

	logic    start;
	opcode_t op;
	sample_t a;
	sample_t b;
	sample_t c;
	logic    saturate;
	shift_t  shift;

	logic    done;
	sample_t result; // Valid with done.

	modport seq (
		output start, op, a, b, c, saturate, shift,
		input  done, result
	);

	modport alu (
		input  start, op, a, b, c, saturate, shift,
		output done, result
	);

endinterface

/* common/dsp_pkg.sv */
`include "dsp_settings.svh"

package dsp_pkg;

	typedef logic signed [`DSP_DATA_WIDTH-1:0] sample_t;
	typedef logic signed [2*`DSP_DATA_WIDTH-1:0] wide_t; // Full product.
	typedef logic [$clog2(`DSP_N_BLOCKS)-1:0] block_idx_t;
	typedef logic [$clog2(`DSP_N_REGISTERS)-1:0] reg_addr_t;
	typedef logic [`DSP_SHIFT_WIDTH-1:0] shift_t;
	typedef logic [`DSP_INSTR_WIDTH-1:0] instr_t;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_MUL  = 4'd3,
		OP_MAD  = 4'd4,
		OP_MOV  = 4'd5,
		OP_ABS  = 4'd6,
		OP_LSH  = 4'd7,
		OP_RSH  = 4'd8,
		OP_ARSH = 4'd9
	} opcode_t;

	// Same order as the top bits of instr_t; the low 3 bits are unused.
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t src_a;
		reg_addr_t src_b;
		reg_addr_t src_c;
		reg_addr_t dest;
		logic      a_is_reg; // 1 selects the block register, 0 a channel.
		logic      b_is_reg;
		logic      c_is_reg;
		logic      dest_is_reg;
		logic      saturate;
		shift_t    shift;
	} decoded_instr_t;

endpackage

/* common/dsp_settings.svh */
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Sample and instruction widths.
`define DSP_DATA_WIDTH 16
`define DSP_INSTR_WIDTH 32
`define DSP_SHIFT_WIDTH 4

// Storage sizes.
`define DSP_N_BLOCKS 16
`define DSP_N_REGISTERS 16 // Per block.
`define DSP_N_CHANNELS 16

`endif

/* common/reg_port_if.sv */
interface reg_port_if import dsp_pkg::*; ();

	logic       rd_is_reg;
	block_idx_t rd_block;
	reg_addr_t  rd_addr;
	sample_t    rd_data; // One cycle after the address.

	logic       wr_en;
	logic       wr_is_reg;
	block_idx_t wr_block;
	reg_addr_t  wr_addr;
	sample_t    wr_data;

	modport seq (
		output rd_is_reg, rd_block, rd_addr,
		output wr_en, wr_is_reg, wr_block, wr_addr, wr_data,
		input  rd_data
	);

	modport rf (
		input  rd_is_reg, rd_block, rd_addr,
		input  wr_en, wr_is_reg, wr_block, wr_addr, wr_data,
		output rd_data
	);

endinterface

/* dsp_core.f */
+incdir+common
+incdir+test
common/dsp_pkg.sv
common/reg_port_if.sv
common/alu_if.sv
hw/register_file.sv
hw/alu/block_alu.sv
hw/control/instr_decoder.sv
hw/control/block_sequencer.sv
hw/dsp_core.sv
test/dsp_core_assertions.sv
test/dsp_core_tb.sv

/* hw/alu/block_alu.sv */
`include "dsp_settings.svh"

module block_alu import dsp_pkg::*; (
	input  logic clk,
	input  logic reset,
	alu_if.alu   alu
);

	localparam int FRAC_BITS = `DSP_DATA_WIDTH - 1;
	localparam sample_t SAMPLE_MAX = {1'b0, {FRAC_BITS{1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {FRAC_BITS{1'b0}}};

	typedef enum logic [2:0] {
		S_IDLE, S_PROD, S_SHIFT, S_SAT, S_MAD_LOAD, S_ADD
	} state_t;

	state_t  state;
	sample_t mul_a;
	sample_t mul_b;
	wide_t   product;
	wide_t   shifted;
	sample_t mul_out;
	sample_t summand_a;
	sample_t summand_b;
	logic signed [`DSP_DATA_WIDTH:0] sum_ext;
	sample_t sum_out;
	sample_t unary_out;

	assign mul_out = !alu.saturate ? shifted[`DSP_DATA_WIDTH-1:0] :
		(shifted > wide_t'(SAMPLE_MAX)) ? SAMPLE_MAX :
		(shifted < wide_t'(SAMPLE_MIN)) ? SAMPLE_MIN :
		shifted[`DSP_DATA_WIDTH-1:0];

	// Shared by ADD, SUB and the MAD tail.
	assign sum_ext = summand_a + summand_b;
	assign sum_out = !alu.saturate ? sum_ext[`DSP_DATA_WIDTH-1:0] :
		(sum_ext > SAMPLE_MAX) ? SAMPLE_MAX :
		(sum_ext < SAMPLE_MIN) ? SAMPLE_MIN :
		sum_ext[`DSP_DATA_WIDTH-1:0];

	always_comb begin
		case (alu.op)
			OP_ABS: unary_out = (alu.a < 0) ? -alu.a : alu.a; // -32768 wraps.
			OP_LSH: unary_out = {alu.a[`DSP_DATA_WIDTH-2:0], 1'b0};
			OP_RSH: unary_out = {1'b0, alu.a[`DSP_DATA_WIDTH-1:1]};
			OP_ARSH: unary_out = alu.a >>> 1;
			default: unary_out = alu.a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			alu.done <= 1'b0;
		end else begin
			alu.done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (alu.start) begin
						if (alu.op inside {OP_ADD, OP_SUB})
							state <= S_ADD;
						else if (alu.op inside {OP_MUL, OP_MAD})
							state <= S_PROD;
						else
							alu.done <= 1'b1;
					end
				end
				S_PROD: state <= S_SHIFT;
				S_SHIFT: state <= S_SAT;
				S_SAT: begin
					if (alu.op == OP_MAD) begin
						state <= S_MAD_LOAD;
					end else begin
						state <= S_IDLE;
						alu.done <= 1'b1;
					end
				end
				S_MAD_LOAD: state <= S_ADD;
				S_ADD: begin
					state <= S_IDLE;
					alu.done <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && alu.start) begin
			summand_a <= alu.a;
			summand_b <= (alu.op == OP_SUB) ? -alu.b : alu.b;
			mul_a <= alu.a;
			mul_b <= alu.b;
			alu.result <= unary_out;
		end
		product <= mul_a * mul_b;
		shifted <= product >>> (FRAC_BITS - alu.shift); // Q15 product back to Q15.
		if (state == S_SAT)
			alu.result <= mul_out;
		if (state == S_MAD_LOAD) begin
			summand_a <= alu.result;
			summand_b <= alu.c;
		end
		if (state == S_ADD)
			alu.result <= sum_out;
	end

endmodule

/* hw/control/block_sequencer.sv */
module block_sequencer import dsp_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           tick,
	input  sample_t        sample_in,
	input  logic           command_reg_write,
	input  block_idx_t     command_block_target,
	input  reg_addr_t      command_reg_target,
	input  sample_t        command_reg_write_val,
	input  decoded_instr_t decoded,
	input  block_idx_t     last_block,
	output logic           ready,
	output sample_t        sample_out,
	output logic           reg_write_ack,
	output block_idx_t     block,
	output logic           load,
	reg_port_if.seq        rf,
	alu_if.seq             alu
);

	typedef enum logic [3:0] {
		S_IDLE, S_SAMPLE, S_LOAD, S_DECODE, S_FETCH_A, S_FETCH_B,
		S_FETCH_C, S_START, S_EXEC, S_NEXT, S_FINISH
	} state_t;

	state_t     state;
	block_idx_t block_q;
	sample_t    sample_q;
	sample_t    a_q;
	sample_t    b_q;
	sample_t    c_q;
	logic       command_prev;
	logic       command_rose;
	logic       pending;
	logic       defer;
	block_idx_t pend_block;
	reg_addr_t  pend_reg;
	sample_t    pend_val;
	logic       need_b;
	logic       need_c;

	assign command_rose = command_reg_write && !command_prev;
	assign defer = command_rose && (!ready || pending); // Busy, or an older write goes first.
	assign need_b = decoded.opcode inside {OP_ADD, OP_SUB, OP_MUL, OP_MAD};
	assign need_c = (decoded.opcode == OP_MAD);

	assign ready = (state == S_IDLE);
	assign reg_write_ack = ready && (pending || command_rose);
	assign load = (state == S_LOAD);
	assign block = block_q;

	assign alu.start = (state == S_START);
	assign alu.op = decoded.opcode;
	assign alu.a = a_q;
	assign alu.b = b_q;
	assign alu.c = c_q;
	assign alu.saturate = decoded.saturate;
	assign alu.shift = decoded.shift;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			block_q <= '0;
			command_prev <= 1'b0;
			pending <= 1'b0;
		end else begin
			command_prev <= command_reg_write;
			if (defer)
				pending <= 1'b1;
			else if (ready)
				pending <= 1'b0;
			case (state)
				S_IDLE: if (tick) state <= S_SAMPLE;
				S_SAMPLE: begin
					block_q <= '0;
					state <= S_LOAD;
				end
				S_LOAD: state <= S_DECODE;
				S_DECODE: begin
					if (decoded.opcode == OP_NOP)
						state <= S_NEXT; // Nothing to write back.
					else
						state <= S_FETCH_A;
				end
				S_FETCH_A: state <= need_b ? S_FETCH_B : S_START;
				S_FETCH_B: state <= need_c ? S_FETCH_C : S_START;
				S_FETCH_C: state <= S_START;
				S_START: state <= S_EXEC;
				S_EXEC: if (alu.done) state <= S_NEXT;
				S_NEXT: begin
					if (block_q == last_block) begin
						state <= S_FINISH;
					end else begin
						block_q <= block_q + 1'b1;
						state <= S_LOAD;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready && tick)
			sample_q <= sample_in;
		if (state == S_FETCH_A)
			a_q <= rf.rd_data;
		if (state == S_FETCH_B)
			b_q <= rf.rd_data;
		if (state == S_FETCH_C)
			c_q <= rf.rd_data;
		if (state == S_FINISH)
			sample_out <= rf.rd_data; // Channel 0, read in S_NEXT.
		if (defer) begin
			pend_block <= command_block_target;
			pend_reg <= command_reg_target;
			pend_val <= command_reg_write_val;
		end
	end

	// Each read address is presented one state ahead of its latch.
	always_comb begin
		rf.rd_block = block_q;
		rf.rd_is_reg = 1'b0;
		rf.rd_addr = '0;
		case (state)
			S_DECODE: begin
				rf.rd_is_reg = decoded.a_is_reg;
				rf.rd_addr = decoded.src_a;
			end
			S_FETCH_A: begin
				rf.rd_is_reg = decoded.b_is_reg;
				rf.rd_addr = decoded.src_b;
			end
			S_FETCH_B: begin
				rf.rd_is_reg = decoded.c_is_reg;
				rf.rd_addr = decoded.src_c;
			end
			default: rf.rd_addr = '0;
		endcase
	end

	always_comb begin
		rf.wr_en = 1'b0;
		rf.wr_is_reg = 1'b0;
		rf.wr_block = block_q;
		rf.wr_addr = '0;
		rf.wr_data = sample_q; // Channel 0 in S_SAMPLE.
		case (state)
			S_IDLE: begin
				rf.wr_en = reg_write_ack;
				rf.wr_is_reg = 1'b1;
				rf.wr_block = pending ? pend_block : command_block_target;
				rf.wr_addr = pending ? pend_reg : command_reg_target;
				rf.wr_data = pending ? pend_val : command_reg_write_val;
			end
			S_SAMPLE: rf.wr_en = 1'b1;
			S_EXEC: begin
				rf.wr_en = alu.done;
				rf.wr_is_reg = decoded.dest_is_reg;
				rf.wr_addr = decoded.dest;
				rf.wr_data = alu.result;
			end
			default: rf.wr_en = 1'b0;
		endcase
	end

endmodule

/* hw/control/instr_decoder.sv */
`include "dsp_settings.svh"

module instr_decoder import dsp_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           command_instr_write,
	input  block_idx_t     command_block_target,
	input  instr_t         command_instr_write_val,
	input  block_idx_t     block,
	input  logic           load,
	output logic           instr_write_ack,
	output decoded_instr_t decoded,
	output block_idx_t     last_block
);

	localparam int FIELD_BITS = $bits(decoded_instr_t);

	instr_t instrs [`DSP_N_BLOCKS];
	instr_t current;

	assign current = instrs[block];

	always_ff @(posedge clk) begin
		if (command_instr_write)
			instrs[command_block_target] <= command_instr_write_val;
	end

	// Fields sit at the top of the word, so decode is a slice and a cast.
	always_ff @(posedge clk) begin
		if (load)
			decoded <= decoded_instr_t'(current[`DSP_INSTR_WIDTH-1 -: FIELD_BITS]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			instr_write_ack <= 1'b0;
			last_block <= '0;
		end else begin
			instr_write_ack <= command_instr_write;
			if (command_instr_write && command_block_target > last_block)
				last_block <= command_block_target; // Highest block ever written.
		end
	end

endmodule

/* hw/dsp_core.sv */
module dsp_core import dsp_pkg::*; (
	input  logic       clk,
	input  logic       reset,

	input  logic       tick,
	input  sample_t    sample_in,
	output sample_t    sample_out,
	output logic       ready,

	input  logic       command_reg_write,
	input  logic       command_instr_write,
	input  block_idx_t command_block_target,
	input  reg_addr_t  command_reg_target,
	input  instr_t     command_instr_write_val,
	input  sample_t    command_reg_write_val,

	output logic       reg_write_ack,
	output logic       instr_write_ack
);

	reg_port_if rf_bus ();
	alu_if alu_bus ();

	decoded_instr_t decoded;
	block_idx_t     last_block;
	block_idx_t     block;
	logic           load;

	instr_decoder u_instr_decoder (
		.clk                     (clk),
		.reset                   (reset),
		.command_instr_write     (command_instr_write),
		.command_block_target    (command_block_target),
		.command_instr_write_val (command_instr_write_val),
		.block                   (block),
		.load                    (load),
		.instr_write_ack         (instr_write_ack),
		.decoded                 (decoded),
		.last_block              (last_block)
	);

	block_sequencer u_block_sequencer (
		.clk                   (clk),
		.reset                 (reset),
		.tick                  (tick),
		.sample_in             (sample_in),
		.command_reg_write     (command_reg_write),
		.command_block_target  (command_block_target),
		.command_reg_target    (command_reg_target),
		.command_reg_write_val (command_reg_write_val),
		.decoded               (decoded),
		.last_block            (last_block),
		.ready                 (ready),
		.sample_out            (sample_out),
		.reg_write_ack         (reg_write_ack),
		.block                 (block),
		.load                  (load),
		.rf                    (rf_bus.seq),
		.alu                   (alu_bus.seq)
	);

	block_alu u_block_alu (
		.clk   (clk),
		.reset (reset),
		.alu   (alu_bus.alu)
	);

	register_file u_register_file (
		.clk   (clk),
		.reset (reset),
		.port  (rf_bus.rf)
	);

endmodule

/* hw/register_file.sv */
`include "dsp_settings.svh"

module register_file import dsp_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	reg_port_if.rf  port
);

	localparam int N_REGS = `DSP_N_BLOCKS * `DSP_N_REGISTERS;

	sample_t regs [N_REGS]; // Indexed by {block, register}.
	sample_t channels [`DSP_N_CHANNELS];

	always_ff @(posedge clk) begin
		if (port.wr_en && port.wr_is_reg)
			regs[{port.wr_block, port.wr_addr}] <= port.wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DSP_N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else if (port.wr_en && !port.wr_is_reg) begin
			channels[port.wr_addr] <= port.wr_data;
		end
	end

	// Old value on a read of the address being written.
	always_ff @(posedge clk) begin
		if (port.rd_is_reg)
			port.rd_data <= regs[{port.rd_block, port.rd_addr}];
		else
			port.rd_data <= channels[port.rd_addr];
	end

endmodule

/* test/dsp_core_assertions.sv */
module dsp_core_assertions (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic ready,
	input logic command_reg_write,
	input logic command_instr_write,
	input logic instr_write_ack,
	input logic reg_write_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int assert_errors = 0;

	instr_ack_follows: assert property (@(posedge clk) disable iff (reset)
		command_instr_write |=> instr_write_ack)
	else begin
		$error("instr_write_ack did not follow the instruction command");
		assert_errors++;
	end

	instr_ack_only_after_command: assert property (@(posedge clk) disable iff (reset)
		!command_instr_write |=> !instr_write_ack)
	else begin
		$error("instr_write_ack without an instruction command");
		assert_errors++;
	end

	reg_ack_on_idle_command: assert property (@(posedge clk) disable iff (reset)
		ready && $rose(command_reg_write) |-> reg_write_ack)
	else begin
		$error("reg_write_ack missing for a register command while idle");
		assert_errors++;
	end

	ready_falls_on_tick: assert property (@(posedge clk) disable iff (reset)
		ready && tick |=> !ready)
	else begin
		$error("ready stayed high after an accepted tick");
		assert_errors++;
	end

endmodule

bind dsp_core dsp_core_assertions u_assertions (
	.clk                 (clk),
	.reset               (reset),
	.tick                (tick),
	.ready               (ready),
	.command_reg_write   (command_reg_write),
	.command_instr_write (command_instr_write),
	.instr_write_ack     (instr_write_ack),
	.reg_write_ack       (reg_write_ack)
);

/* test/dsp_core_model.svh */
`ifndef DSP_CORE_MODEL_SVH
`define DSP_CORE_MODEL_SVH

`include "dsp_settings.svh"

instr_t  model_instrs [`DSP_N_BLOCKS];
sample_t model_regs [`DSP_N_BLOCKS][`DSP_N_REGISTERS]; // Unwritten entries stay X, as in the DUT.
sample_t model_channels [`DSP_N_CHANNELS] = '{default: '0};
int      model_last_block = 0;

function automatic sample_t fit16(longint v, logic sat);
	if (sat && v > 32767)
		return 16'sh7fff;
	if (sat && v < -32768)
		return 16'sh8000;
	return v[15:0]; // Wraps to the low 16 bits.
endfunction

function automatic sample_t model_op(opcode_t op, sample_t a, sample_t b, sample_t c,
		logic sat, shift_t shift);
	sample_t neg_b;
	sample_t m;
	sample_t r;
	longint  p;
	neg_b = -b; // Negated at 16 bits, so -32768 stays put.
	p = longint'(a) * longint'(b);
	p = p >>> (15 - int'(shift));
	m = fit16(p, sat);
	case (op)
		OP_ADD: r = fit16(longint'(a) + longint'(b), sat);
		OP_SUB: r = fit16(longint'(a) + longint'(neg_b), sat);
		OP_MUL: r = m;
		OP_MAD: r = fit16(longint'(m) + longint'(c), sat);
		OP_ABS: begin
			if (a < 0)
				r = -a;
			else
				r = a;
		end
		OP_LSH: r = a << 1;
		OP_RSH: r = $unsigned(a) >> 1;
		OP_ARSH: r = a >>> 1;
		default: r = a;
	endcase
	return r;
endfunction

// Field positions from the top bit: op, a, b, c, dest, four kind flags, sat, shift.
function automatic sample_t model_program(sample_t s);
	instr_t  w;
	sample_t a;
	sample_t b;
	sample_t c;
	sample_t r;
	model_channels[0] = s;
	for (int blk = 0; blk <= model_last_block; blk++) begin
		w = model_instrs[blk];
		if (w[31:28] == OP_NOP)
			continue;
		a = w[11] ? model_regs[blk][w[27:24]] : model_channels[w[27:24]];
		b = w[10] ? model_regs[blk][w[23:20]] : model_channels[w[23:20]];
		c = w[9] ? model_regs[blk][w[19:16]] : model_channels[w[19:16]];
		r = model_op(opcode_t'(w[31:28]), a, b, c, w[7], w[6:3]);
		if (w[8])
			model_regs[blk][w[15:12]] = r;
		else
			model_channels[w[15:12]] = r;
	end
	return model_channels[0];
endfunction

`endif

/* test/dsp_core_tb.sv */
`include "dsp_settings.svh"

module dsp_core_tb import dsp_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ADD_SUB = 16;
	localparam int N_MUL_MAD = 16;
	localparam int N_CHAIN = 3;
	localparam int N_RANDOM = 50;
	localparam int N_TICKS = 2 + N_ADD_SUB + N_MUL_MAD + N_CHAIN + N_RANDOM;
	localparam int CYCLE_LIMIT = N_TICKS * `DSP_N_BLOCKS * 12 + 2000;

	logic       clk = 1'b0;
	logic       reset;
	logic       tick;
	sample_t    sample_in;
	sample_t    sample_out;
	logic       ready;
	logic       command_reg_write;
	logic       command_instr_write;
	block_idx_t command_block_target;
	reg_addr_t  command_reg_target;
	instr_t     command_instr_write_val;
	sample_t    command_reg_write_val;
	logic       reg_write_ack;
	logic       instr_write_ack;

	int      pass_count = 0;
	int      fail_count = 0;
	int      test_checks;
	int      test_fails;
	int      reg_ack_count = 0;
	int      cycle_count = 0;
	logic    ready_prev = 1'b1;
	sample_t expected [$]; // One entry per accepted tick.
	sample_t expected_now;

	`include "dsp_core_model.svh"

	dsp_core u_dsp_core (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped finishing its program", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (reg_write_ack === 1'b1)
			reg_ack_count++;
	end

	// Each rise of ready ends one accepted tick.
	always @(negedge clk) begin
		if (ready === 1'b1 && ready_prev === 1'b0) begin
			if (expected.size() == 0) begin
				$display("Error at %0t: ready rose although no tick was accepted", $time);
				fail_count++;
			end else begin
				expected_now = expected.pop_front();
				check_sample("sample_out", expected_now, sample_out);
			end
		end
		ready_prev = ready;
	end

	task automatic check_sample(string name, sample_t exp, sample_t act);
		if (act !== exp) begin
			$display("Fail %0t %s expected %0d got %0d", $time, name, exp, act);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Fail %0t %s expected %b got %b", $time, name, exp, act);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			$display("Fail %0t %s expected %0d got %0d", $time, name, exp, act);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	function automatic instr_t make_instr(opcode_t op, reg_addr_t sa, reg_addr_t sb,
			reg_addr_t sc, reg_addr_t dst, logic [3:0] kinds, logic sat, shift_t sh);
		return {op, sa, sb, sc, dst, kinds, sat, sh, 3'b000}; // Kinds are a, b, c, dest.
	endfunction

	task automatic write_instr(block_idx_t blk, instr_t w);
		@(posedge clk);
		#1;
		command_instr_write = 1'b1;
		command_block_target = blk;
		command_instr_write_val = w;
		@(posedge clk);
		#1;
		command_instr_write = 1'b0;
		check_bit("instr_write_ack", 1'b1, instr_write_ack);
		@(posedge clk);
		#1;
		check_bit("instr_write_ack", 1'b0, instr_write_ack);
		model_instrs[blk] = w;
		if (blk > model_last_block)
			model_last_block = blk;
	endtask

	task automatic write_reg(block_idx_t blk, reg_addr_t r, sample_t v, int hold);
		int acks_before;
		acks_before = reg_ack_count;
		@(posedge clk);
		#1;
		command_reg_write = 1'b1;
		command_block_target = blk;
		command_reg_target = r;
		command_reg_write_val = v;
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		command_reg_write = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		check_count("reg_write_ack pulses", 1, reg_ack_count - acks_before);
		model_regs[blk][r] = v;
	endtask

	task automatic issue_tick(sample_t s, logic poke_busy);
		@(posedge clk);
		#1;
		while (ready !== 1'b1) begin
			@(posedge clk);
			#1;
		end
		tick = 1'b1;
		sample_in = s;
		expected.push_back(model_program(s));
		@(posedge clk);
		#1;
		tick = 1'b0;
		check_bit("ready", 1'b0, ready);
		if (poke_busy) begin
			tick = 1'b1; // Must be ignored while busy.
			sample_in = ~s;
			@(posedge clk);
			#1;
			tick = 1'b0;
		end
	endtask

	task automatic wait_done();
		while (expected.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic begin_test();
		test_checks = pass_count + fail_count;
		test_fails = fail_count;
	endtask

	task automatic end_test(string name);
		$display("Test %s finished: %0d checks, %0d errors", name,
			pass_count + fail_count - test_checks, fail_count - test_fails);
	endtask

	task automatic run_add_sub();
		opcode_t op;
		sample_t a;
		sample_t b;
		logic    sat;
		begin_test();
		for (int i = 0; i < N_ADD_SUB; i++) begin
			op = ($urandom_range(0, 1) == 0) ? OP_ADD : OP_SUB;
			a = sample_t'($urandom);
			b = sample_t'($urandom);
			sat = $urandom_range(0, 1);
			if (i < 8) begin
				sat = i[0];
				case (i / 2)
					0: begin op = OP_ADD; a = 16'sh7fff; b = 16'sd1; end
					1: begin op = OP_ADD; a = 16'sh8000; b = 16'sh8000; end
					2: begin op = OP_SUB; a = 16'sd0; b = 16'sh8000; end
					default: begin op = OP_SUB; a = 16'sh8000; b = 16'sd1; end
				endcase
			end
			write_reg(4'd0, 4'd2, b, 1);
			write_instr(4'd0, make_instr(op, 4'd0, 4'd2, 4'd0, 4'd0, 4'b0100, sat, 4'd0));
			issue_tick(a, 1'b0);
			wait_done();
		end
		end_test("add_sub");
	endtask

	task automatic run_mul_mad();
		opcode_t op;
		sample_t a;
		sample_t b;
		sample_t c;
		shift_t  sh;
		logic    sat;
		begin_test();
		for (int i = 0; i < N_MUL_MAD; i++) begin
			op = ($urandom_range(0, 1) == 0) ? OP_MUL : OP_MAD;
			a = sample_t'($urandom);
			b = sample_t'($urandom);
			c = sample_t'($urandom);
			sh = $urandom_range(0, 15);
			sat = $urandom_range(0, 1);
			if (i < 4) begin
				a = 16'sh8000; // Largest product.
				b = 16'sh8000;
				sh = (i < 2) ? 4'd15 : 4'd0;
				sat = i[0];
			end
			write_reg(4'd0, 4'd3, b, 1);
			write_reg(4'd0, 4'd4, c, 1);
			write_instr(4'd0, make_instr(op, 4'd0, 4'd3, 4'd4, 4'd0, 4'b0110, sat, sh));
			issue_tick(a, 1'b0);
			wait_done();
		end
		end_test("mul_mad");
	endtask

	task automatic run_chain();
		begin_test();
		write_reg(4'd2, 4'd6, sample_t'($urandom), 1);
		write_instr(4'd0, make_instr(OP_ABS, 4'd0, 4'd0, 4'd0, 4'd1, 4'b0000, 1'b0, 4'd0));
		write_instr(4'd1, make_instr(OP_LSH, 4'd1, 4'd0, 4'd0, 4'd2, 4'b0000, 1'b0, 4'd0));
		write_instr(4'd2, make_instr(OP_MOV, 4'd6, 4'd0, 4'd0, 4'd4, 4'b1000, 1'b0, 4'd0));
		write_instr(4'd3, make_instr(OP_RSH, 4'd0, 4'd0, 4'd0, 4'd3, 4'b0000, 1'b0, 4'd0));
		write_instr(4'd4, make_instr(OP_ARSH, 4'd3, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 4'd0));
		write_instr(4'd5, make_instr(OP_ADD, 4'd0, 4'd2, 4'd0, 4'd0, 4'b0000, 1'b1, 4'd0));
		write_instr(4'd6, make_instr(OP_SUB, 4'd0, 4'd4, 4'd0, 4'd0, 4'b0000, 1'b1, 4'd0));
		issue_tick(16'sh8000, 1'b0);
		wait_done();
		issue_tick(16'sh7fff, 1'b0);
		wait_done();
		issue_tick(sample_t'($urandom), 1'b0);
		wait_done();
		end_test("chain");
	endtask

	task automatic run_random();
		begin_test();
		for (int i = 0; i < N_RANDOM; i++) begin
			issue_tick(sample_t'($urandom), 1'b1);
		end
		wait_done();
		end_test("back_to_back");
	endtask

	initial begin
		void'($urandom(46));
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_reg_write = 1'b0;
		command_instr_write = 1'b0;
		command_block_target = '0;
		command_reg_target = '0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test();
		check_bit("ready", 1'b1, ready);
		check_bit("reg_write_ack", 1'b0, reg_write_ack);
		check_bit("instr_write_ack", 1'b0, instr_write_ack);
		write_instr(4'd0, make_instr(OP_NOP, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 4'd0));
		issue_tick(16'sd1234, 1'b0);
		wait_done();
		end_test("reset_nop");

		begin_test();
		repeat (3) begin
			write_instr(4'd0, make_instr(OP_NOP, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 4'd0));
		end
		write_reg(4'd0, 4'd1, 16'sh1357, 4); // Held high, one ack expected.
		write_reg(4'd9, 4'd9, 16'sh2468, 1);
		write_instr(4'd0, make_instr(OP_MOV, 4'd1, 4'd0, 4'd0, 4'd0, 4'b1000, 1'b0, 4'd0));
		issue_tick(16'sd0, 1'b0);
		wait_done();
		end_test("command_protocol");

		run_add_sub();
		run_mul_mad();
		run_chain();
		run_random();

		$display("Checks passed: %0d, failed: %0d, assertion failures: %0d",
			pass_count, fail_count, u_dsp_core.u_assertions.assert_errors);
		if (fail_count == 0 && u_dsp_core.u_assertions.assert_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
